// File: flist.f
+incdir+test
hdl/div_pkg.sv
hdl/div_decode.sv
hdl/div_execute.sv
hdl/div_result.sv
hdl/div_unit.sv
test/div_unit_tb.sv

// File: run.sh
#!/bin/sh
# Build the divide unit testbench with Verilator and run it.
# Exit status is 0 only if the log holds the pass line.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  -f flist.f \
  --top-module div_unit_tb \
  -o div_unit_sim \
  && ./obj_dir/div_unit_sim > sim.log 2>&1 \
  || echo "Build or simulation returned an error" >> sim.log

cat sim.log

grep -q "^TEST RESULT: PASS$" sim.log && exit 0 || exit 1

// File: test/div_vectors.svh
////////////////////
// Expected values are the RISC-V results, written out by hand
// Included inside the testbench module after the div_pkg import
////////////////////
`ifndef DIV_VECTORS_SVH
`define DIV_VECTORS_SVH

// Columns: op, dividend, divisor, tag, expected result
typedef struct packed {
  div_op_e op;
  xlen_t   dividend;
  xlen_t   divisor;
  tag_t    tag;
  xlen_t   expected;
} div_vec_t;

localparam int NUM_VEC = 27;

localparam div_vec_t VECTORS [NUM_VEC] = '{
  // Unsigned
  '{OP_DIVU, 32'h00000064, 32'h00000007, 5'd1,  32'h0000000E},
  '{OP_REMU, 32'h00000064, 32'h00000007, 5'd2,  32'h00000002},
  '{OP_DIVU, 32'hDEADBEEF, 32'h00000001, 5'd3,  32'hDEADBEEF},
  '{OP_REMU, 32'hDEADBEEF, 32'h00000001, 5'd4,  32'h00000000},
  '{OP_DIVU, 32'h00000005, 32'h00000009, 5'd5,  32'h00000000},
  '{OP_REMU, 32'h00000005, 32'h00000009, 5'd6,  32'h00000005},
  '{OP_DIVU, 32'hFFFFFFFF, 32'hFFFFFFFF, 5'd7,  32'h00000001},
  '{OP_REMU, 32'hFFFFFFFF, 32'hFFFFFFFF, 5'd8,  32'h00000000},
  '{OP_DIVU, 32'hFFFFFFFF, 32'h00000010, 5'd9,  32'h0FFFFFFF},
  '{OP_REMU, 32'hFFFFFFFF, 32'h00000010, 5'd10, 32'h0000000F},
  '{OP_DIVU, 32'h80000000, 32'h00000003, 5'd11, 32'h2AAAAAAA},
  // Signed, all four sign pairs of 20 and 3
  '{OP_DIV,  32'h00000014, 32'h00000003, 5'd12, 32'h00000006},
  '{OP_REM,  32'h00000014, 32'h00000003, 5'd13, 32'h00000002},
  '{OP_DIV,  32'hFFFFFFEC, 32'h00000003, 5'd14, 32'hFFFFFFFA},
  '{OP_REM,  32'hFFFFFFEC, 32'h00000003, 5'd15, 32'hFFFFFFFE},
  '{OP_DIV,  32'h00000014, 32'hFFFFFFFD, 5'd16, 32'hFFFFFFFA},
  '{OP_REM,  32'h00000014, 32'hFFFFFFFD, 5'd17, 32'h00000002},
  '{OP_DIV,  32'hFFFFFFEC, 32'hFFFFFFFD, 5'd18, 32'h00000006},
  '{OP_REM,  32'hFFFFFFEC, 32'hFFFFFFFD, 5'd19, 32'hFFFFFFFE},
  // Divide by zero and signed overflow
  '{OP_DIVU, 32'h000004D2, 32'h00000000, 5'd20, 32'hFFFFFFFF},
  '{OP_REMU, 32'h000004D2, 32'h00000000, 5'd21, 32'h000004D2},
  '{OP_DIV,  32'hFFFFFFF9, 32'h00000000, 5'd22, 32'hFFFFFFFF},
  '{OP_REM,  32'hFFFFFFF9, 32'h00000000, 5'd23, 32'hFFFFFFF9},
  '{OP_DIV,  32'h80000000, 32'hFFFFFFFF, 5'd24, 32'h80000000},
  '{OP_REM,  32'h80000000, 32'hFFFFFFFF, 5'd25, 32'h00000000},
  '{OP_DIV,  32'h80000000, 32'h00000002, 5'd26, 32'hC0000000},
  '{OP_REM,  32'h80000000, 32'h00000002, 5'd27, 32'h00000000}
};

`endif

// File: test/div_unit_tb.sv
////////////////////
// Issues the vector table under one request credit, grants random
// response credits, stops at the first mismatch
////////////////////
`default_nettype none

module div_unit_tb;

  import div_pkg::*;

  `include "div_vectors.svh"

  localparam int CLK_PERIOD      = 100;
  localparam int RESET_CYCLES    = 16;
  localparam int IDLE_CYCLES     = 4;
  localparam int DRAIN_CYCLES    = 100;
  localparam int CREDIT_MAX      = 4;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + IDLE_CYCLES + 200 * NUM_VEC + DRAIN_CYCLES;
  localparam logic [15:0] LFSR_SEED = 16'd54;

  logic      clk;
  logic      rst_n;
  logic      req_valid;
  div_req_t  req;
  logic      req_credit;
  logic      resp_credit;
  logic      resp_valid;
  div_resp_t resp;

  int          credit_pulses;
  int          resp_credits_held;
  logic [15:0] lfsr;
  logic        grant_bit;

  div_unit #(
    .RESP_CREDIT_MAX (CREDIT_MAX)
  ) i_div_unit (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid   (req_valid),
    .req         (req),
    .req_credit  (req_credit),
    .resp_credit (resp_credit),
    .resp_valid  (resp_valid),
    .resp        (resp)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////
  // Helpers
  ////////////////////
  task automatic fail_run(input string what);
    $display("%s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hB400;
    end
    return n;
  endfunction

  function automatic div_req_t make_request(input div_vec_t v);
    div_req_t r;
    r.op       = v.op;
    r.dividend = v.dividend;
    r.divisor  = v.divisor;
    r.tag      = v.tag;
    return r;
  endfunction

  ////////////////////
  // Request side
  ////////////////////
  always @(posedge clk) begin
    if (!rst_n) begin
      credit_pulses <= 0;
    end else if (req_credit) begin
      credit_pulses <= credit_pulses + 1;
    end
  end

  initial begin : drive_requests
    int issued;
    int credits;
    clk       = 1'b0;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    // Nothing may come out before the first request
    repeat (IDLE_CYCLES) begin
      @(posedge clk);
      assert (req_credit === 1'b0 && resp_valid === 1'b0)
        else fail_run("req_credit or resp_valid went high after reset with no request");
    end
    issued = 0;
    while (issued < NUM_VEC) begin
      @(posedge clk);
      // One credit at start, one back per req_credit pulse
      credits = 1 + credit_pulses - issued;
      assert (credits <= 1)
        else fail_run("req_credit pulsed more often than requests were accepted");
      if (credits > 0) begin
        req_valid <= 1'b1;
        req       <= make_request(VECTORS[issued]);
        issued++;
      end else begin
        req_valid <= 1'b0;
      end
    end
    @(posedge clk);
    req_valid <= 1'b0;
  end

  ////////////////////
  // Response credits
  ////////////////////
  // Mirrors the DUT credit count, so a grant never overflows it
  initial begin : grant_credits
    resp_credit       = 1'b0;
    resp_credits_held = 0;
    lfsr              = LFSR_SEED;
    forever begin
      @(posedge clk);
      if (!rst_n) begin
        resp_credit       <= 1'b0;
        resp_credits_held = 0;
        lfsr              = LFSR_SEED;
      end else begin
        assert (resp_valid !== 1'b1 || resp_credits_held > 0)
          else fail_run("resp_valid rose while the testbench had granted no credit");
        resp_credits_held = resp_credits_held + int'(resp_credit) - int'(resp_valid);
        grant_bit = lfsr[0];
        lfsr      = lfsr_step(lfsr);
        if (grant_bit && resp_credits_held < CREDIT_MAX) begin
          resp_credit <= 1'b1;
        end else begin
          resp_credit <= 1'b0;
        end
      end
    end
  end

  ////////////////////
  // Response checks
  ////////////////////
  initial begin : check_responses
    int k;
    wait (rst_n === 1'b1);
    for (k = 0; k < NUM_VEC; k++) begin
      do begin
        @(posedge clk);
      end while (resp_valid !== 1'b1);
      assert (resp.value === VECTORS[k].expected)
        else fail_run($sformatf("FAILED resp.value entry %0d: got %08h expected %08h",
                                k, resp.value, VECTORS[k].expected));
      assert (resp.tag === VECTORS[k].tag)
        else fail_run($sformatf("FAILED resp.tag entry %0d: got %02h expected %02h",
                                k, resp.tag, VECTORS[k].tag));
    end
    // Any further response would be a duplicate
    repeat (DRAIN_CYCLES) begin
      @(posedge clk);
      assert (resp_valid !== 1'b1)
        else fail_run("A response arrived after the last table entry");
    end
    assert (credit_pulses == NUM_VEC)
      else fail_run($sformatf("FAILED req_credit pulse count: got %h expected %h",
                              credit_pulses, NUM_VEC));
    $display("TEST RESULT: PASS");
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    fail_run("Watchdog expired before all responses were checked");
  end

endmodule

`default_nettype wire

// File: hdl/div_unit.sv
////////////////////
// Credit-based divide unit for DIV, DIVU, REM and REMU
// Up to three operations in flight, responses return in order
////////////////////
`default_nettype none

module div_unit #(
  parameter int unsigned RESP_CREDIT_MAX = 4
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req_valid,
  input  div_pkg::div_req_t   req,
  output logic                req_credit,
  input  logic                resp_credit,
  output logic                resp_valid,
  output div_pkg::div_resp_t  resp
);

  import div_pkg::*;

  // Decode to execute
  logic      work_valid;
  logic      work_ready;
  div_work_t work;

  // Execute to result
  logic      raw_valid;
  logic      raw_ready;
  div_raw_t  raw;

  div_decode i_div_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req        (req),
    .req_credit (req_credit),
    .work_valid (work_valid),
    .work_ready (work_ready),
    .work       (work)
  );

  div_execute i_div_execute (
    .clk        (clk),
    .rst_n      (rst_n),
    .work_valid (work_valid),
    .work       (work),
    .work_ready (work_ready),
    .raw_valid  (raw_valid),
    .raw_ready  (raw_ready),
    .raw        (raw)
  );

  div_result #(
    .RESP_CREDIT_MAX (RESP_CREDIT_MAX)
  ) i_div_result (
    .clk         (clk),
    .rst_n       (rst_n),
    .raw_valid   (raw_valid),
    .raw         (raw),
    .raw_ready   (raw_ready),
    .resp_credit (resp_credit),
    .resp_valid  (resp_valid),
    .resp        (resp)
  );

endmodule

`default_nettype wire

// File: hdl/div_result.sv
////////////////////
// Applies signs and holds one response until a credit is available
// Consumer must not grant more than RESP_CREDIT_MAX credits
////////////////////
`default_nettype none

module div_result #(
  parameter int unsigned RESP_CREDIT_MAX = 4
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                raw_valid,
  input  div_pkg::div_raw_t   raw,
  output logic                raw_ready,
  input  logic                resp_credit,
  output logic                resp_valid,
  output div_pkg::div_resp_t  resp
);

  import div_pkg::*;

  localparam int unsigned CNT_W = $clog2(RESP_CREDIT_MAX + 1);

  logic             full;
  logic [CNT_W-1:0] credit_cnt;
  xlen_t            quot_s;
  xlen_t            rem_s;
  logic             load;

  ////////////////////
  // Sign fix-up
  ////////////////////
  assign quot_s = raw.neg_quot ? (~raw.quot + xlen_t'(1)) : raw.quot;

  // Remainder follows the sign of the dividend
  assign rem_s = raw.neg_rem ? (~raw.rem + xlen_t'(1)) : raw.rem;

  ////////////////////
  // Holding register
  ////////////////////
  assign raw_ready = !full;
  assign load      = raw_valid && raw_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full <= 1'b0;
    end else if (load) begin
      full <= 1'b1;
    end else if (resp_valid) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      resp.value <= raw.want_rem ? rem_s : quot_s;
      resp.tag   <= raw.tag;
    end
  end

  ////////////////////
  // Response credits
  ////////////////////
  // Leaves on the first cycle with both a result and a credit
  assign resp_valid = full && (credit_cnt != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_cnt <= '0;
    end else begin
      case ({resp_credit, resp_valid})
        2'b10: begin
          credit_cnt <= credit_cnt + CNT_W'(1);
        end
        2'b01: begin
          credit_cnt <= credit_cnt - CNT_W'(1);
        end
        default: begin
          credit_cnt <= credit_cnt;
        end
      endcase
    end
  end

  a_credit_no_overflow: assert property (
    @(posedge clk) disable iff (!rst_n)
    resp_credit |-> (credit_cnt != CNT_W'(RESP_CREDIT_MAX))
  );

endmodule

`default_nettype wire

// File: hdl/div_execute.sv
////////////////////
// Non-restoring unsigned divide, XLEN steps plus one correction
// Divisor zero gives all ones and the dividend as remainder
////////////////////
`default_nettype none

module div_execute (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                work_valid,
  input  div_pkg::div_work_t  work,
  output logic                work_ready,
  output logic                raw_valid,
  input  logic                raw_ready,
  output div_pkg::div_raw_t   raw
);

  import div_pkg::*;

  exec_state_e   state;
  count_t        count;

  // Partial remainder carries one extra bit for its sign
  logic [XLEN:0] part_rem;
  xlen_t         quot;
  xlen_t         dvs;
  logic          neg_quot;
  logic          neg_rem;
  logic          want_rem;
  tag_t          tag;

  logic [XLEN:0] dvs_ext;
  logic [XLEN:0] shifted;
  logic [XLEN:0] step_rem;
  logic          start;

  assign work_ready = (state == ST_IDLE);
  assign raw_valid  = (state == ST_DONE);
  assign start      = work_valid && work_ready;

  ////////////////////
  // One divide step
  ////////////////////
  assign dvs_ext = {1'b0, dvs};

  // Next dividend bit enters from the top of the quotient register
  assign shifted = {part_rem[XLEN-1:0], quot[XLEN-1]};

  // Negative remainder adds the divisor back, otherwise subtract
  assign step_rem = part_rem[XLEN] ? (shifted + dvs_ext) : (shifted - dvs_ext);

  ////////////////////
  // Control FSM
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      count <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= ST_ITER;
            count <= '0;
          end
        end
        ST_ITER: begin
          count <= count + count_t'(1);
          if (count == count_t'(XLEN - 1)) begin
            state <= ST_CORRECT;
          end
        end
        ST_CORRECT: begin
          state <= ST_DONE;
        end
        ST_DONE: begin
          if (raw_ready) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  ////////////////////
  // Datapath
  ////////////////////
  always_ff @(posedge clk) begin
    if (start) begin
      quot     <= work.dividend;
      part_rem <= '0;
      dvs      <= work.divisor;
      neg_quot <= work.neg_quot;
      neg_rem  <= work.neg_rem;
      want_rem <= work.want_rem;
      tag      <= work.tag;
    end else if (state == ST_ITER) begin
      part_rem <= step_rem;
      // Quotient bit is one when the new remainder is not negative
      quot     <= {quot[XLEN-2:0], ~step_rem[XLEN]};
    end else if ((state == ST_CORRECT) && part_rem[XLEN]) begin
      part_rem <= part_rem + dvs_ext;
    end
  end

  assign raw = '{
    quot:     quot,
    rem:      part_rem[XLEN-1:0],
    neg_quot: neg_quot,
    neg_rem:  neg_rem,
    want_rem: want_rem,
    tag:      tag
  };

  a_count_in_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    count <= count_t'(XLEN)
  );

endmodule

`default_nettype wire

// File: hdl/div_decode.sv
////////////////////
// Holds one request. The issuer starts with one credit and
// must not assert req_valid again until req_credit returns it
////////////////////
`default_nettype none

module div_decode (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req_valid,
  input  div_pkg::div_req_t   req,
  output logic                req_credit,
  output logic                work_valid,
  input  logic                work_ready,
  output div_pkg::div_work_t  work
);

  import div_pkg::*;

  logic      signed_op;
  logic      sign_eff;
  logic      dvd_neg;
  logic      dvs_neg;
  xlen_t     dvd_mag;
  xlen_t     dvs_mag;
  div_work_t work_d;

  ////////////////////
  // Sign rules
  ////////////////////
  assign signed_op = (req.op == OP_DIV) || (req.op == OP_REM);

  // Divide by zero is treated as unsigned so the raw dividend
  // comes back as the remainder and the quotient stays all ones
  assign sign_eff = signed_op && (req.divisor != '0);

  assign dvd_neg = sign_eff && req.dividend[XLEN-1];
  assign dvs_neg = sign_eff && req.divisor[XLEN-1];

  // Most negative value maps onto itself, which is 2^31 unsigned
  assign dvd_mag = dvd_neg ? (~req.dividend + xlen_t'(1)) : req.dividend;
  assign dvs_mag = dvs_neg ? (~req.divisor + xlen_t'(1)) : req.divisor;

  assign work_d = '{
    dividend: dvd_mag,
    divisor:  dvs_mag,
    neg_quot: dvd_neg ^ dvs_neg,
    neg_rem:  dvd_neg,
    want_rem: (req.op == OP_REM) || (req.op == OP_REMU),
    tag:      req.tag
  };

  ////////////////////
  // Entry
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      work_valid <= 1'b0;
    end else if (req_valid) begin
      work_valid <= 1'b1;
    end else if (work_ready) begin
      work_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid) begin
      work <= work_d;
    end
  end

  // Credit goes back as soon as execute takes the entry
  assign req_credit = work_valid && work_ready;

  // A request on a full entry means the issuer overspent its credit
  a_req_needs_credit: assert property (
    @(posedge clk) disable iff (!rst_n)
    req_valid |-> !work_valid
  );

endmodule

`default_nettype wire

// File: hdl/div_pkg.sv
////////////////////
// Widths and hand-off structs shared by all divide unit blocks
// XLEN is fixed at 32 and the tag is a 5-bit register address
////////////////////
`default_nettype none

package div_pkg;

  ////////////////////
  // Widths
  ////////////////////
  localparam int unsigned XLEN = 32;

  // One data word
  typedef logic [XLEN-1:0] xlen_t;
  // Destination register address
  typedef logic [4:0] tag_t;
  // Iteration count, holds 0 to XLEN
  typedef logic [5:0] count_t;

  ////////////////////
  // Encodings
  ////////////////////
  typedef enum logic [1:0] {
    OP_DIV  = 2'd0,
    OP_DIVU = 2'd1,
    OP_REM  = 2'd2,
    OP_REMU = 2'd3
  } div_op_e;

  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,
    ST_ITER    = 2'd1,
    ST_CORRECT = 2'd2,
    ST_DONE    = 2'd3
  } exec_state_e;

  ////////////////////
  // Hand-off structs
  ////////////////////
  typedef struct packed {
    div_op_e op;
    xlen_t   dividend;
    xlen_t   divisor;
    tag_t    tag;
  } div_req_t;

  // Operands already as magnitudes, signs kept as flags
  typedef struct packed {
    xlen_t dividend;
    xlen_t divisor;
    logic  neg_quot;
    logic  neg_rem;
    logic  want_rem;
    tag_t  tag;
  } div_work_t;

  // Unsigned results, flags passed through untouched
  typedef struct packed {
    xlen_t quot;
    xlen_t rem;
    logic  neg_quot;
    logic  neg_rem;
    logic  want_rem;
    tag_t  tag;
  } div_raw_t;

  typedef struct packed {
    xlen_t value;
    tag_t  tag;
  } div_resp_t;

endpackage

`default_nettype wire
